// File: dma_pkg.sv
package dma_pkg;

    // Word address and data widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Word count per transfer, zero is not a legal count
    localparam int LEN_W = 8;

    // Copy channels and their index width
    localparam int NUM_CH = 4;
    localparam int CH_W   = 2;

    // Descriptor queue depth
    localparam int REQ_DEPTH = 4;

    // Per channel data buffer, also the limit of reads in flight
    localparam int BUF_DEPTH = 4;

    // Register offsets
    localparam logic [2:0] REG_SRC     = 3'd0;
    localparam logic [2:0] REG_DST     = 3'd1;
    localparam logic [2:0] REG_LEN     = 3'd2;
    localparam logic [2:0] REG_CTRL    = 3'd3;
    localparam logic [2:0] REG_IRQ_CLR = 3'd4;

    // One queued copy job
    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [LEN_W-1:0]  len;
    } dma_desc_t;

endpackage

// File: dma_mem_if.sv
`timescale 1ns/1ps

interface dma_mem_if;

    logic                       req_valid;
    logic                       req_ready;
    logic                       req_we;
    logic [dma_pkg::ADDR_W-1:0] req_addr;
    logic [dma_pkg::DATA_W-1:0] req_wdata;

    // Read return, one pulse per read, in request order
    logic                       rsp_valid;
    logic [dma_pkg::DATA_W-1:0] rsp_rdata;

    modport requester (
        output req_valid, req_we, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport server (
        input  req_valid, req_we, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

// File: dma_fifo.sv
`timescale 1ns/1ps

module dma_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         push_i,
    input  payload_t                     data_i,
    input  logic                         pop_i,
    output payload_t                     data_o,
    output logic                         full_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);

    payload_t                     mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0]   count_q;

    // Pointers wrap on their own, DEPTH is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = int'(count_q) == DEPTH;
    assign empty_o = count_q == '0;
    assign count_o = count_q;

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o));
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o));

endmodule

// File: dma_regs.sv
`timescale 1ns/1ps

module dma_regs (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       reg_valid_i,
    output logic                       reg_ready_o,
    input  logic [2:0]                 reg_addr_i,
    input  logic [dma_pkg::DATA_W-1:0] reg_wdata_i,
    input  logic [dma_pkg::NUM_CH-1:0] ch_idle_i,
    input  logic [dma_pkg::NUM_CH-1:0] ch_done_i,
    output logic [dma_pkg::NUM_CH-1:0] ch_start_o,
    output dma_pkg::dma_desc_t         ch_desc_o,
    output logic [dma_pkg::NUM_CH-1:0] irq_o
);

    dma_pkg::dma_desc_t         stage_q;
    dma_pkg::dma_desc_t         head;
    dma_pkg::dma_desc_t         desc_q;
    logic                       reg_wr;
    logic                       q_push;
    logic                       q_pop;
    logic                       q_full;
    logic                       q_empty;
    logic [dma_pkg::NUM_CH-1:0] avail;
    logic [dma_pkg::NUM_CH-1:0] pick;
    logic [dma_pkg::NUM_CH-1:0] start_q;
    logic [dma_pkg::NUM_CH-1:0] irq_q;
    logic [dma_pkg::NUM_CH-1:0] irq_clr;

    // Only a start command can stall, and only on a full queue
    assign reg_ready_o = !(reg_addr_i == dma_pkg::REG_CTRL && q_full);
    assign reg_wr      = reg_valid_i && reg_ready_o;
    assign q_push      = reg_wr && reg_addr_i == dma_pkg::REG_CTRL && reg_wdata_i[0];

    always_ff @(posedge clk_i) begin
        if (reg_wr) begin
            case (reg_addr_i)
                dma_pkg::REG_SRC: stage_q.src <= reg_wdata_i[dma_pkg::ADDR_W-1:0];
                dma_pkg::REG_DST: stage_q.dst <= reg_wdata_i[dma_pkg::ADDR_W-1:0];
                dma_pkg::REG_LEN: stage_q.len <= reg_wdata_i[dma_pkg::LEN_W-1:0];
                default: ;
            endcase
        end
    end

    dma_fifo #(
        .payload_t (dma_pkg::dma_desc_t),
        .DEPTH     (dma_pkg::REQ_DEPTH)
    ) u_req_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (q_push),
        .data_i  (stage_q),
        .pop_i   (q_pop),
        .data_o  (head),
        .full_o  (q_full),
        .empty_o (q_empty),
        .count_o ()
    );

    // A channel started last cycle still shows idle for one more cycle
    assign avail = ch_idle_i & ~start_q;
    assign q_pop = !q_empty && avail != '0;

    always_comb begin
        pick = '0;
        for (int k = 0; k < dma_pkg::NUM_CH; k++) begin
            if (avail[k] && pick == '0) begin
                pick[k] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            start_q <= '0;
        end else begin
            start_q <= q_pop ? pick : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_pop) begin
            desc_q <= head;
        end
    end

    assign irq_clr = (reg_wr && reg_addr_i == dma_pkg::REG_IRQ_CLR) ?
                     reg_wdata_i[dma_pkg::NUM_CH-1:0] : '0;

    // Set beats clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            irq_q <= '0;
        end else begin
            irq_q <= (irq_q & ~irq_clr) | ch_done_i;
        end
    end

    assign ch_start_o = start_q;
    assign ch_desc_o  = desc_q;
    assign irq_o      = irq_q;

    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ch_start_o & ~ch_idle_i) == '0);

endmodule

// File: dma_channel.sv
`timescale 1ns/1ps

module dma_channel (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               start_i,
    input  dma_pkg::dma_desc_t desc_i,
    output logic               idle_o,
    output logic               done_o,
    dma_mem_if.requester       mem
);

    logic                                    busy_q;
    logic                                    done_q;
    logic                                    hold_q;
    logic                                    hold_we_q;
    logic [dma_pkg::ADDR_W-1:0]              rd_addr_q;
    logic [dma_pkg::ADDR_W-1:0]              wr_addr_q;
    logic [dma_pkg::LEN_W-1:0]               rd_left_q;
    logic [dma_pkg::LEN_W-1:0]               wr_left_q;
    logic [$clog2(dma_pkg::BUF_DEPTH+1)-1:0] inflight_q;
    logic [$clog2(dma_pkg::BUF_DEPTH+1)-1:0] buf_count;
    logic                                    buf_full;
    logic                                    buf_empty;
    logic [dma_pkg::DATA_W-1:0]              buf_data;
    logic                                    want_rd;
    logic                                    want_wr;
    logic                                    rd_hs;
    logic                                    wr_hs;

    // Reads only go out with a free buffer slot reserved for the reply
    assign want_wr = busy_q && !buf_empty;
    assign want_rd = busy_q && rd_left_q != '0 &&
                     int'(inflight_q) + int'(buf_count) < dma_pkg::BUF_DEPTH;

    // Writes win, but a stalled request keeps its kind until taken
    assign mem.req_valid = want_wr || want_rd;
    assign mem.req_we    = hold_q ? hold_we_q : want_wr;
    assign mem.req_addr  = mem.req_we ? wr_addr_q : rd_addr_q;
    assign mem.req_wdata = buf_data;

    assign rd_hs = mem.req_valid && mem.req_ready && !mem.req_we;
    assign wr_hs = mem.req_valid && mem.req_ready && mem.req_we;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            hold_q     <= 1'b0;
            hold_we_q  <= 1'b0;
            rd_left_q  <= '0;
            wr_left_q  <= '0;
            inflight_q <= '0;
        end else begin
            done_q    <= wr_hs && int'(wr_left_q) == 1;
            hold_q    <= mem.req_valid && !mem.req_ready;
            hold_we_q <= mem.req_we;
            if (start_i) begin
                busy_q    <= 1'b1;
                rd_left_q <= desc_i.len;
                wr_left_q <= desc_i.len;
            end else begin
                if (rd_hs) begin
                    rd_left_q <= rd_left_q - 1'b1;
                end
                if (wr_hs) begin
                    wr_left_q <= wr_left_q - 1'b1;
                    if (int'(wr_left_q) == 1) begin
                        busy_q <= 1'b0;
                    end
                end
            end
            case ({rd_hs, mem.rsp_valid})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rd_addr_q <= desc_i.src;
            wr_addr_q <= desc_i.dst;
        end else begin
            if (rd_hs) begin
                rd_addr_q <= rd_addr_q + 1'b1;
            end
            if (wr_hs) begin
                wr_addr_q <= wr_addr_q + 1'b1;
            end
        end
    end

    dma_fifo #(
        .payload_t (logic [dma_pkg::DATA_W-1:0]),
        .DEPTH     (dma_pkg::BUF_DEPTH)
    ) u_buf (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (mem.rsp_valid),
        .data_i  (mem.rsp_rdata),
        .pop_i   (wr_hs),
        .data_o  (buf_data),
        .full_o  (buf_full),
        .empty_o (buf_empty),
        .count_o (buf_count)
    );

    assign idle_o = !busy_q;
    assign done_o = done_q;

    a_rsp_has_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.rsp_valid |-> !buf_full);

endmodule

// File: dma_mem_arbiter.sv
`timescale 1ns/1ps

module dma_mem_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    output logic                       mem_req_we_o,
    output logic [dma_pkg::ADDR_W-1:0] mem_req_addr_o,
    output logic [dma_pkg::DATA_W-1:0] mem_req_wdata_o,
    input  logic                       mem_rsp_valid_i,
    input  logic [dma_pkg::DATA_W-1:0] mem_rsp_rdata_i,
    dma_mem_if.server                  ch [dma_pkg::NUM_CH]
);

    logic [dma_pkg::NUM_CH-1:0] req_v;
    logic [dma_pkg::NUM_CH-1:0] req_we;
    logic [dma_pkg::ADDR_W-1:0] req_addr  [dma_pkg::NUM_CH];
    logic [dma_pkg::DATA_W-1:0] req_wdata [dma_pkg::NUM_CH];
    logic [dma_pkg::CH_W-1:0]   last_q;
    logic [dma_pkg::CH_W-1:0]   lock_idx_q;
    logic [dma_pkg::CH_W-1:0]   cand;
    logic [dma_pkg::CH_W-1:0]   pick;
    logic [dma_pkg::CH_W-1:0]   sel;
    logic [dma_pkg::CH_W-1:0]   idx_head;
    logic                       lock_q;
    logic                       hs;
    logic                       idx_empty;

    for (genvar k = 0; k < dma_pkg::NUM_CH; k++) begin : g_ch
        assign req_v[k]     = ch[k].req_valid;
        assign req_we[k]    = ch[k].req_we;
        assign req_addr[k]  = ch[k].req_addr;
        assign req_wdata[k] = ch[k].req_wdata;

        assign ch[k].req_ready = mem_req_ready_i && int'(sel) == k;
        // Reply belongs to the oldest read still open
        assign ch[k].rsp_valid = mem_rsp_valid_i && int'(idx_head) == k;
        assign ch[k].rsp_rdata = mem_rsp_rdata_i;
    end

    // Nearest requester after the last one served
    always_comb begin
        pick = last_q;
        cand = last_q;
        for (int i = dma_pkg::NUM_CH; i >= 1; i--) begin
            cand = last_q + i[dma_pkg::CH_W-1:0];
            if (req_v[cand]) begin
                pick = cand;
            end
        end
    end

    assign sel = lock_q ? lock_idx_q : pick;

    assign mem_req_valid_o = req_v[sel];
    assign mem_req_we_o    = req_we[sel];
    assign mem_req_addr_o  = req_addr[sel];
    assign mem_req_wdata_o = req_wdata[sel];
    assign hs              = mem_req_valid_o && mem_req_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            last_q     <= '1;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= mem_req_valid_o && !mem_req_ready_i;
            lock_idx_q <= sel;
            if (hs) begin
                last_q <= sel;
            end
        end
    end

    dma_fifo #(
        .payload_t (logic [dma_pkg::CH_W-1:0]),
        .DEPTH     (dma_pkg::NUM_CH * dma_pkg::BUF_DEPTH)
    ) u_idx_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (hs && !mem_req_we_o),
        .data_i  (sel),
        .pop_i   (mem_rsp_valid_i),
        .data_o  (idx_head),
        .full_o  (),
        .empty_o (idx_empty),
        .count_o ()
    );

    a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_valid_i |-> !idx_empty);

endmodule

// File: dma_top.sv
`timescale 1ns/1ps

module dma_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       reg_valid_i,
    output logic                       reg_ready_o,
    input  logic [2:0]                 reg_addr_i,
    input  logic [dma_pkg::DATA_W-1:0] reg_wdata_i,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    output logic                       mem_req_we_o,
    output logic [dma_pkg::ADDR_W-1:0] mem_req_addr_o,
    output logic [dma_pkg::DATA_W-1:0] mem_req_wdata_o,
    input  logic                       mem_rsp_valid_i,
    input  logic [dma_pkg::DATA_W-1:0] mem_rsp_rdata_i,
    output logic [dma_pkg::NUM_CH-1:0] irq_o
);

    logic [dma_pkg::NUM_CH-1:0] ch_start;
    logic [dma_pkg::NUM_CH-1:0] ch_idle;
    logic [dma_pkg::NUM_CH-1:0] ch_done;
    dma_pkg::dma_desc_t         ch_desc;

    dma_mem_if mem_if [dma_pkg::NUM_CH] ();

    dma_regs u_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .reg_valid_i (reg_valid_i),
        .reg_ready_o (reg_ready_o),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .ch_idle_i   (ch_idle),
        .ch_done_i   (ch_done),
        .ch_start_o  (ch_start),
        .ch_desc_o   (ch_desc),
        .irq_o       (irq_o)
    );

    // One descriptor bus, the start pulse picks the channel
    for (genvar k = 0; k < dma_pkg::NUM_CH; k++) begin : g_ch
        dma_channel u_ch (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .start_i (ch_start[k]),
            .desc_i  (ch_desc),
            .idle_o  (ch_idle[k]),
            .done_o  (ch_done[k]),
            .mem     (mem_if[k])
        );
    end

    dma_mem_arbiter u_arb (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .ch              (mem_if)
    );

endmodule

// File: dma_checker.sv
`timescale 1ns/1ps

module dma_checker #(
    parameter int                   N_XFER   = 1,
    parameter int                   DESC_W   = $bits(dma_pkg::dma_desc_t),
    parameter logic [N_XFER*DESC_W-1:0] XFER_TAB = '0,
    parameter logic [31:0]          FILL_KEY = 32'h0
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       mem_req_valid_i,
    input  logic                       mem_req_ready_i,
    input  logic                       mem_req_we_i,
    input  logic [dma_pkg::ADDR_W-1:0] mem_req_addr_i,
    input  logic [dma_pkg::DATA_W-1:0] mem_req_wdata_i,
    input  logic [dma_pkg::NUM_CH-1:0] irq_i,
    output int                         done_cnt_o,
    output int                         err_cnt_o,
    output int                         irq_cnt_o,
    output logic                       overlap_o
);

    int                         wr_cnt   [N_XFER];
    int                         xfer_err [N_XFER];
    logic [dma_pkg::NUM_CH-1:0] irq_prev;

    // Entry 0 sits in the top bits of the table
    function automatic dma_pkg::dma_desc_t table_entry(input int i);
        return XFER_TAB[(N_XFER-1-i)*DESC_W +: DESC_W];
    endfunction

    function automatic logic [31:0] fill_word(input logic [15:0] addr);
        return {16'h0, addr} ^ FILL_KEY;
    endfunction

    always @(posedge clk_i) begin : watch
        dma_pkg::dma_desc_t d;
        dma_pkg::dma_desc_t e;
        int                 hit;
        int                 off;
        logic [31:0]        exp_w;
        if (!rst_ni) begin
            irq_prev   = '0;
            done_cnt_o = 0;
            err_cnt_o  = 0;
            irq_cnt_o  = 0;
            overlap_o  = 1'b0;
            for (int i = 0; i < N_XFER; i++) begin
                wr_cnt[i]   = 0;
                xfer_err[i] = 0;
            end
        end else begin
            irq_cnt_o = irq_cnt_o + $countones(irq_i & ~irq_prev);
            irq_prev  = irq_i;
            if (mem_req_valid_i && mem_req_ready_i && mem_req_we_i) begin
                hit = -1;
                for (int i = 0; i < N_XFER; i++) begin
                    d = table_entry(i);
                    if (int'(mem_req_addr_i) >= int'(d.dst) &&
                        int'(mem_req_addr_i) < int'(d.dst) + int'(d.len)) begin
                        hit = i;
                    end
                end
                if (hit < 0) begin
                    $display("FAIL %0t: write to %h outside every destination range",
                             $time, mem_req_addr_i);
                    err_cnt_o++;
                end else begin
                    d     = table_entry(hit);
                    off   = int'(mem_req_addr_i) - int'(d.dst);
                    exp_w = fill_word(d.src + 16'(off));
                    // Another transfer part way through means channels ran in parallel
                    for (int j = 0; j < N_XFER; j++) begin
                        e = table_entry(j);
                        if (j != hit && wr_cnt[j] > 0 && wr_cnt[j] < int'(e.len)) begin
                            overlap_o = 1'b1;
                        end
                    end
                    // Each word leaves a channel once and in address order
                    if (off != wr_cnt[hit]) begin
                        $display("FAIL %0t: xfer %0d wrote word %0d, expected word %0d",
                                 $time, hit, off, wr_cnt[hit]);
                        xfer_err[hit]++;
                        err_cnt_o++;
                    end
                    if (mem_req_wdata_i !== exp_w) begin
                        $display("FAIL %0t: xfer %0d addr %h got %h expected %h",
                                 $time, hit, mem_req_addr_i, mem_req_wdata_i, exp_w);
                        xfer_err[hit]++;
                        err_cnt_o++;
                    end
                    wr_cnt[hit]++;
                    if (wr_cnt[hit] == int'(d.len)) begin
                        $display("xfer %0d: %0d words %h -> %h, %0d errors",
                                 hit, d.len, d.src, d.dst, xfer_err[hit]);
                        done_cnt_o++;
                    end
                end
            end
        end
    end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int          N_XFER   = 12;
    localparam int          DESC_W   = $bits(dma_pkg::dma_desc_t);
    localparam logic [31:0] FILL_KEY = 32'hc3a5_5a3c;

    // Entries of source, destination and length with entry 0 first
    localparam logic [N_XFER*DESC_W-1:0] XFER_TAB = {
        16'h0100, 16'h8000, 8'd1,
        16'h0200, 16'h8100, 8'd16,
        16'h0300, 16'h8200, 8'd9,
        16'h0310, 16'h8300, 8'd12,
        16'h0400, 16'h8400, 8'd20,
        16'h0500, 16'h8500, 8'd7,
        16'h0207, 16'h8600, 8'd14,
        16'h0600, 16'h8700, 8'd11,
        16'h0700, 16'h8800, 8'd18,
        16'h0800, 16'h8900, 8'd5,
        16'h0900, 16'h8a00, 8'd10,
        16'h0a00, 16'h8b00, 8'd13
    };

    logic                       clk_i;
    logic                       rst_ni;
    logic                       reg_valid_i;
    logic                       reg_ready_o;
    logic [2:0]                 reg_addr_i;
    logic [dma_pkg::DATA_W-1:0] reg_wdata_i;
    logic                       mem_req_valid_o;
    logic                       mem_req_ready_i;
    logic                       mem_req_we_o;
    logic [dma_pkg::ADDR_W-1:0] mem_req_addr_o;
    logic [dma_pkg::DATA_W-1:0] mem_req_wdata_o;
    logic                       mem_rsp_valid_i;
    logic [dma_pkg::DATA_W-1:0] mem_rsp_rdata_i;
    logic [dma_pkg::NUM_CH-1:0] irq_o;

    int          done_cnt;
    int          chk_err_cnt;
    int          irq_cnt;
    logic        overlap;
    int          tb_err_cnt;
    int          stall_cnt;
    int          cycle_cnt;
    int          last_due;
    logic [31:0] lfsr_q;
    logic [15:0] rsp_addr_q [$];
    int          rsp_due_q  [$];

    dma_top dut (.*);

    dma_checker #(
        .N_XFER   (N_XFER),
        .DESC_W   (DESC_W),
        .XFER_TAB (XFER_TAB),
        .FILL_KEY (FILL_KEY)
    ) u_chk (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_we_i    (mem_req_we_o),
        .mem_req_addr_i  (mem_req_addr_o),
        .mem_req_wdata_i (mem_req_wdata_o),
        .irq_i           (irq_o),
        .done_cnt_o      (done_cnt),
        .err_cnt_o       (chk_err_cnt),
        .irq_cnt_o       (irq_cnt),
        .overlap_o       (overlap)
    );

    always #50 clk_i = ~clk_i;

    function automatic dma_pkg::dma_desc_t table_entry(input int i);
        return XFER_TAB[(N_XFER-1-i)*DESC_W +: DESC_W];
    endfunction

    function automatic logic [31:0] fill_word(input logic [15:0] addr);
        return {16'h0, addr} ^ FILL_KEY;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Memory model with random ready and in-order read data after 1 to 4 cycles
    always @(posedge clk_i) begin : mem_model
        logic [31:0] r;
        int          due;
        cycle_cnt++;
        if (rst_ni && mem_req_valid_o && mem_req_ready_i && !mem_req_we_o) begin
            take_bits(2, r);
            due = cycle_cnt + 1 + int'(r[1:0]);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_addr_q.push_back(mem_req_addr_o);
            rsp_due_q.push_back(due);
        end
        #1;
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle_cnt) begin
            mem_rsp_valid_i = 1'b1;
            mem_rsp_rdata_i = fill_word(rsp_addr_q.pop_front());
            void'(rsp_due_q.pop_front());
        end else begin
            mem_rsp_valid_i = 1'b0;
        end
        take_bits(2, r);
        mem_req_ready_i = rst_ni && (r[1:0] != 2'b00);
    end

    // All register tasks start and end 1 ns after a rising edge
    task automatic clear_irq();
        if (irq_o != '0) begin
            reg_valid_i = 1'b1;
            reg_addr_i  = dma_pkg::REG_IRQ_CLR;
            reg_wdata_i = 32'(irq_o);
            @(posedge clk_i);
            #1;
            reg_valid_i = 1'b0;
        end
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            clear_irq();
            reg_valid_i = 1'b1;
            reg_addr_i  = addr;
            reg_wdata_i = data;
            @(negedge clk_i);
            taken = reg_ready_o;
            if (!reg_ready_o) begin
                stall_cnt++;
            end
            @(posedge clk_i);
            #1;
            reg_valid_i = 1'b0;
        end
    endtask

    task automatic issue_xfer(input int i);
        dma_pkg::dma_desc_t d;
        d = table_entry(i);
        reg_write(dma_pkg::REG_SRC, 32'(d.src));
        reg_write(dma_pkg::REG_DST, 32'(d.dst));
        reg_write(dma_pkg::REG_LEN, 32'(d.len));
        reg_write(dma_pkg::REG_CTRL, 32'h1);
    endtask

    task automatic wait_done(input int n);
        while (!(done_cnt >= n && irq_cnt >= n && irq_o == '0)) begin
            if (irq_o != '0) begin
                clear_irq();
            end else begin
                @(posedge clk_i);
                #1;
            end
        end
    endtask

    // Watchdog scaled by the total word count
    initial begin : watchdog
        dma_pkg::dma_desc_t d;
        int                 limit;
        limit = 500;
        for (int i = 0; i < N_XFER; i++) begin
            d = table_entry(i);
            limit += 40 * int'(d.len);
        end
        repeat (limit) @(posedge clk_i);
        $display("Timeout after %0d cycles, %0d of %0d transfers finished",
                 limit, done_cnt, N_XFER);
        $display("sim failed");
        $finish;
    end

    initial begin
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        reg_valid_i     = 1'b0;
        reg_addr_i      = '0;
        reg_wdata_i     = '0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_rdata_i = '0;
        lfsr_q          = 32'h07f2_fe58;
        tb_err_cnt      = 0;
        stall_cnt       = 0;
        cycle_cnt       = 0;
        last_due        = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        if (reg_ready_o !== 1'b1 || irq_o !== '0 || mem_req_valid_o !== 1'b0) begin
            $display("FAIL %0t: ready, irq or request wrong after reset", $time);
            tb_err_cnt++;
        end

        // One transfer alone and then the rest back to back
        issue_xfer(0);
        wait_done(1);
        for (int i = 1; i < N_XFER; i++) begin
            issue_xfer(i);
        end
        wait_done(N_XFER);
        repeat (4) begin
            @(posedge clk_i);
            #1;
        end

        if (irq_cnt != N_XFER || irq_o != '0) begin
            $display("FAIL %0t: %0d interrupts for %0d transfers, irq_o %h",
                     $time, irq_cnt, N_XFER, irq_o);
            tb_err_cnt++;
        end
        if (stall_cnt == 0) begin
            $display("reg_ready_o never dropped although the queue should fill");
            tb_err_cnt++;
        end
        if (overlap !== 1'b1) begin
            $display("Writes of different transfers never interleaved on the memory port");
            tb_err_cnt++;
        end
        $display("transfers %0d/%0d, irqs %0d, stall cycles %0d, errors %0d",
                 done_cnt, N_XFER, irq_cnt, stall_cnt, chk_err_cnt + tb_err_cnt);
        if (chk_err_cnt + tb_err_cnt == 0 && done_cnt == N_XFER) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: list.f
dma_pkg.sv
dma_mem_if.sv
dma_fifo.sv
dma_regs.sv
dma_channel.sv
dma_mem_arbiter.sv
dma_top.sv
dma_checker.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f list.f -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
else
    exit 1
fi
